//--- list.f
+incdir+logic
+incdir+verif
logic/core_pkg.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/ex_mem_stage.sv
logic/result_stage.sv
logic/pipe_core.sv
verif/pipe_core_tb.sv

//--- logic/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data and instruction word width
`define NB_DATA 32

// register index, 32 architectural registers
`define NB_REGWR 5

// retire sequence number, wraps at 128
`define NB_SEQ 7

// data memory depth in words
`define DMEM_WORDS 16

`endif

//--- logic/core_pkg.sv
`default_nettype none

package core_pkg;

	// primary opcodes, MIPS numbering
	typedef enum logic [5:0] {
		OP_RTYPE = 6'd0,
		OP_ADDI  = 6'd8,
		OP_ORI   = 6'd13,
		OP_LW    = 6'd35,
		OP_SW    = 6'd43
	} opcode_e;

	// function field of register-format words
	typedef enum logic [5:0] {
		FN_ADD = 6'd32,
		FN_SUB = 6'd34,
		FN_AND = 6'd36,
		FN_OR  = 6'd37,
		FN_SLT = 6'd42
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4
	} alu_op_e;

	// same 32 bits, register view and immediate view
	typedef union packed {
		struct packed {
			opcode_e    opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			funct_e     funct;
		} r;
		struct packed {
			opcode_e     opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i;
	} instr_word_t;

endpackage

`default_nettype wire

//--- logic/decode_stage.sv
`default_nettype none
`include "core_macros.svh"

module decode_stage import core_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  run_i,
	input  logic                  instr_req_i,
	input  logic [`NB_DATA-1:0]   instr_i,
	output logic                  instr_ack_o,
	input  logic                  wr_en_i,
	input  logic [`NB_REGWR-1:0]  wr_reg_i,
	input  logic [`NB_DATA-1:0]   wr_data_i,
	output logic                  dec_valid_o,
	output logic [`NB_SEQ-1:0]    dec_seq_o,
	output alu_op_e               dec_alu_op_o,
	output logic [15:0]           dec_imm_o,
	output logic                  dec_imm_sext_o,
	output logic                  dec_use_imm_o,
	output logic [`NB_DATA-1:0]   dec_rs_val_o,
	output logic [`NB_DATA-1:0]   dec_rt_val_o,
	output logic [`NB_REGWR-1:0]  dec_dest_o,
	output logic                  dec_mem_rd_o,
	output logic                  dec_mem_wr_o,
	output logic                  dec_reg_wr_o
);

	instr_word_t           word;
	logic [`NB_DATA-1:0]   regs [32];
	logic [31:0]           pending_q;
	logic [`NB_SEQ-1:0]    seq_q;
	logic                  ack_q;
	alu_op_e               alu_op;
	logic                  use_imm;
	logic                  imm_sext;
	logic                  mem_rd;
	logic                  mem_wr;
	logic                  writes;
	logic                  reg_wr;
	logic [`NB_REGWR-1:0]  dest;
	logic                  hazard;
	logic                  accept;

	assign word = instr_i;
	assign instr_ack_o = ack_q;

	always_comb
	begin
		alu_op = ALU_ADD;
		use_imm = 1'b0;
		imm_sext = 1'b0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		writes = 1'b0;
		dest = word.r.rd;
		case (word.r.opcode)
			OP_RTYPE:
			begin
				writes = 1'b1;
				case (word.r.funct)
					FN_ADD: alu_op = ALU_ADD;
					FN_SUB: alu_op = ALU_SUB;
					FN_AND: alu_op = ALU_AND;
					FN_OR:  alu_op = ALU_OR;
					FN_SLT: alu_op = ALU_SLT;
					// unknown function retires as no-op
					default: writes = 1'b0;
				endcase
			end
			OP_ADDI, OP_LW:
			begin
				use_imm = 1'b1;
				imm_sext = 1'b1;
				mem_rd = (word.i.opcode == OP_LW);
				writes = 1'b1;
				dest = word.i.rt;
			end
			OP_ORI:
			begin
				alu_op = ALU_OR;
				use_imm = 1'b1;
				writes = 1'b1;
				dest = word.i.rt;
			end
			OP_SW:
			begin
				use_imm = 1'b1;
				imm_sext = 1'b1;
				mem_wr = 1'b1;
				dest = word.i.rt;
			end
			default: writes = 1'b0;
		endcase
		// register 0 is never written
		reg_wr = writes && (dest != '0);
	end

	// stall on pending sources and on a pending destination to keep write order
	assign hazard = pending_q[word.r.rs] | pending_q[word.r.rt] | pending_q[dest];
	assign accept = run_i && instr_req_i && !ack_q && !hazard;

	// four-phase handshake where ack drops once req is gone
	always_ff @(posedge clock)
	begin
		if (reset)
			ack_q <= 1'b0;
		else if (accept)
			ack_q <= 1'b1;
		else if (ack_q && !instr_req_i)
			ack_q <= 1'b0;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pending_q <= '0;
			seq_q <= '0;
		end
		else
		begin
			if (wr_en_i)
				pending_q[wr_reg_i] <= 1'b0;
			if (accept && reg_wr)
				pending_q[dest] <= 1'b1;
			if (accept)
				seq_q <= seq_q + 1'b1;
		end
	end

	// register file with its write port driven by the result stage
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int k = 0; k < 32; k++)
				regs[k] <= '0;
		end
		else if (wr_en_i && (wr_reg_i != '0))
			regs[wr_reg_i] <= wr_data_i;
	end

	// decode to execute register
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			dec_valid_o <= 1'b0;
			dec_alu_op_o <= ALU_ADD;
			dec_imm_sext_o <= 1'b0;
			dec_use_imm_o <= 1'b0;
			dec_mem_rd_o <= 1'b0;
			dec_mem_wr_o <= 1'b0;
			dec_reg_wr_o <= 1'b0;
		end
		else if (run_i)
		begin
			dec_valid_o <= accept;
			dec_alu_op_o <= alu_op;
			dec_imm_sext_o <= imm_sext;
			dec_use_imm_o <= use_imm;
			dec_mem_rd_o <= mem_rd;
			dec_mem_wr_o <= mem_wr;
			dec_reg_wr_o <= reg_wr;
		end
	end

	always_ff @(posedge clock)
	begin
		if (run_i)
		begin
			dec_seq_o <= seq_q;
			dec_imm_o <= word.i.imm;
			dec_rs_val_o <= regs[word.r.rs];
			dec_rt_val_o <= regs[word.r.rt];
			dec_dest_o <= dest;
		end
	end

	// req seen at the edge where ack dropped
	ack_holds_during_req: assert property (@(posedge clock) disable iff (reset)
		$fell(instr_ack_o) |-> !$past(instr_req_i))
		else $error("instr_ack_o fell while instr_req_i high");

	// every write-back must come from an accepted, scoreboarded instruction
	wb_targets_pending: assert property (@(posedge clock) disable iff (reset)
		wr_en_i |-> (wr_reg_i != '0) && pending_q[wr_reg_i])
		else $error("write-back to register %0d not pending", wr_reg_i);

endmodule

`default_nettype wire

//--- logic/ex_mem_stage.sv
`default_nettype none
`include "core_macros.svh"

module ex_mem_stage
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  run_i,
	input  logic                  valid_i,
	input  logic [`NB_SEQ-1:0]    seq_i,
	input  logic [`NB_DATA-1:0]   alu_result_i,
	input  logic [`NB_DATA-1:0]   data_wr_to_mem_i,
	input  logic [`NB_REGWR-1:0]  write_reg_i,
	input  logic [1:0]            mem_signals_i,
	input  logic [1:0]            wb_signals_i,
	output logic                  valid_o,
	output logic [`NB_SEQ-1:0]    seq_o,
	output logic [`NB_DATA-1:0]   alu_result_o,
	output logic [`NB_DATA-1:0]   data_wr_to_mem_o,
	output logic [`NB_REGWR-1:0]  write_reg_o,
	output logic [1:0]            mem_signals_o,
	output logic [1:0]            wb_signals_o
);

	// valid and controls, held while frozen
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid_o <= 1'b0;
			mem_signals_o <= 2'b00;
			wb_signals_o <= 2'b00;
		end
		else if (run_i)
		begin
			valid_o <= valid_i;
			mem_signals_o <= mem_signals_i;
			wb_signals_o <= wb_signals_i;
		end
	end

	// payload
	always_ff @(posedge clock)
	begin
		if (run_i)
		begin
			seq_o <= seq_i;
			alu_result_o <= alu_result_i;
			data_wr_to_mem_o <= data_wr_to_mem_i;
			write_reg_o <= write_reg_i;
		end
	end

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`default_nettype none
`include "core_macros.svh"

module execute_stage import core_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  run_i,
	input  logic                  dec_valid_i,
	input  logic [`NB_SEQ-1:0]    dec_seq_i,
	input  alu_op_e               dec_alu_op_i,
	input  logic [15:0]           dec_imm_i,
	input  logic                  dec_imm_sext_i,
	input  logic                  dec_use_imm_i,
	input  logic [`NB_DATA-1:0]   dec_rs_val_i,
	input  logic [`NB_DATA-1:0]   dec_rt_val_i,
	input  logic [`NB_REGWR-1:0]  dec_dest_i,
	input  logic                  dec_mem_rd_i,
	input  logic                  dec_mem_wr_i,
	input  logic                  dec_reg_wr_i,
	output logic                  ex_valid_o,
	output logic [`NB_SEQ-1:0]    ex_seq_o,
	output logic [`NB_DATA-1:0]   ex_alu_result_o,
	output logic [`NB_DATA-1:0]   ex_store_data_o,
	output logic [`NB_REGWR-1:0]  ex_dest_o,
	output logic [1:0]            ex_mem_signals_o,
	output logic [1:0]            ex_wb_signals_o
);

	logic [`NB_DATA-1:0] imm_ext;
	logic [`NB_DATA-1:0] op_b;
	logic [`NB_DATA-1:0] alu_result;

	// addi, lw and sw sign-extend, ori zero-extends
	assign imm_ext = dec_imm_sext_i ?
		{{(`NB_DATA-16){dec_imm_i[15]}}, dec_imm_i} :
		{{(`NB_DATA-16){1'b0}}, dec_imm_i};
	assign op_b = dec_use_imm_i ? imm_ext : dec_rt_val_i;

	always_comb
	begin
		case (dec_alu_op_i)
			ALU_ADD: alu_result = dec_rs_val_i + op_b;
			ALU_SUB: alu_result = dec_rs_val_i - op_b;
			ALU_AND: alu_result = dec_rs_val_i & op_b;
			ALU_OR:  alu_result = dec_rs_val_i | op_b;
			// signed compare
			ALU_SLT: alu_result = {{(`NB_DATA-1){1'b0}},
				($signed(dec_rs_val_i) < $signed(op_b))};
			default: alu_result = '0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ex_valid_o <= 1'b0;
			ex_mem_signals_o <= 2'b00;
			ex_wb_signals_o <= 2'b00;
		end
		else if (run_i)
		begin
			ex_valid_o <= dec_valid_i;
			// mem: read, write
			ex_mem_signals_o <= {dec_mem_rd_i, dec_mem_wr_i};
			// wb: reg write, load data select
			ex_wb_signals_o <= {dec_reg_wr_i, dec_mem_rd_i};
		end
	end

	always_ff @(posedge clock)
	begin
		if (run_i)
		begin
			ex_seq_o <= dec_seq_i;
			ex_alu_result_o <= alu_result;
			ex_store_data_o <= dec_rt_val_i;
			ex_dest_o <= dec_dest_i;
		end
	end

	alu_op_defined: assert property (@(posedge clock) disable iff (reset)
		dec_valid_i |-> dec_alu_op_i inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT})
		else $error("undefined alu operation %0d from decode", dec_alu_op_i);

endmodule

`default_nettype wire

//--- logic/pipe_core.sv
`default_nettype none
`include "core_macros.svh"

module pipe_core import core_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  run_i,
	input  logic                  instr_req_i,
	input  logic [`NB_DATA-1:0]   instr_i,
	output logic                  instr_ack_o,
	output logic                  wb_valid_o,
	output logic [`NB_SEQ-1:0]    wb_seq_o,
	output logic                  wb_write_o,
	output logic [`NB_REGWR-1:0]  wb_reg_o,
	output logic [`NB_DATA-1:0]   wb_data_o
);

	// decode to execute
	logic                  dec_valid;
	logic [`NB_SEQ-1:0]    dec_seq;
	alu_op_e               dec_alu_op;
	logic [15:0]           dec_imm;
	logic                  dec_imm_sext;
	logic                  dec_use_imm;
	logic [`NB_DATA-1:0]   dec_rs_val;
	logic [`NB_DATA-1:0]   dec_rt_val;
	logic [`NB_REGWR-1:0]  dec_dest;
	logic                  dec_mem_rd;
	logic                  dec_mem_wr;
	logic                  dec_reg_wr;

	// execute to ex_mem
	logic                  ex_valid;
	logic [`NB_SEQ-1:0]    ex_seq;
	logic [`NB_DATA-1:0]   ex_alu_result;
	logic [`NB_DATA-1:0]   ex_store_data;
	logic [`NB_REGWR-1:0]  ex_dest;
	logic [1:0]            ex_mem_signals;
	logic [1:0]            ex_wb_signals;

	// ex_mem to result
	logic                  mem_valid;
	logic [`NB_SEQ-1:0]    mem_seq;
	logic [`NB_DATA-1:0]   mem_alu_result;
	logic [`NB_DATA-1:0]   mem_store_data;
	logic [`NB_REGWR-1:0]  mem_dest;
	logic [1:0]            mem_mem_signals;
	logic [1:0]            mem_wb_signals;

	// write-back into the register file
	logic                  wr_en;
	logic [`NB_REGWR-1:0]  wr_reg;
	logic [`NB_DATA-1:0]   wr_data;

	decode_stage i_decode_stage (
		.clock          (clock),
		.reset          (reset),
		.run_i          (run_i),
		.instr_req_i    (instr_req_i),
		.instr_i        (instr_i),
		.instr_ack_o    (instr_ack_o),
		.wr_en_i        (wr_en),
		.wr_reg_i       (wr_reg),
		.wr_data_i      (wr_data),
		.dec_valid_o    (dec_valid),
		.dec_seq_o      (dec_seq),
		.dec_alu_op_o   (dec_alu_op),
		.dec_imm_o      (dec_imm),
		.dec_imm_sext_o (dec_imm_sext),
		.dec_use_imm_o  (dec_use_imm),
		.dec_rs_val_o   (dec_rs_val),
		.dec_rt_val_o   (dec_rt_val),
		.dec_dest_o     (dec_dest),
		.dec_mem_rd_o   (dec_mem_rd),
		.dec_mem_wr_o   (dec_mem_wr),
		.dec_reg_wr_o   (dec_reg_wr)
	);

	execute_stage i_execute_stage (
		.clock            (clock),
		.reset            (reset),
		.run_i            (run_i),
		.dec_valid_i      (dec_valid),
		.dec_seq_i        (dec_seq),
		.dec_alu_op_i     (dec_alu_op),
		.dec_imm_i        (dec_imm),
		.dec_imm_sext_i   (dec_imm_sext),
		.dec_use_imm_i    (dec_use_imm),
		.dec_rs_val_i     (dec_rs_val),
		.dec_rt_val_i     (dec_rt_val),
		.dec_dest_i       (dec_dest),
		.dec_mem_rd_i     (dec_mem_rd),
		.dec_mem_wr_i     (dec_mem_wr),
		.dec_reg_wr_i     (dec_reg_wr),
		.ex_valid_o       (ex_valid),
		.ex_seq_o         (ex_seq),
		.ex_alu_result_o  (ex_alu_result),
		.ex_store_data_o  (ex_store_data),
		.ex_dest_o        (ex_dest),
		.ex_mem_signals_o (ex_mem_signals),
		.ex_wb_signals_o  (ex_wb_signals)
	);

	ex_mem_stage i_ex_mem_stage (
		.clock            (clock),
		.reset            (reset),
		.run_i            (run_i),
		.valid_i          (ex_valid),
		.seq_i            (ex_seq),
		.alu_result_i     (ex_alu_result),
		.data_wr_to_mem_i (ex_store_data),
		.write_reg_i      (ex_dest),
		.mem_signals_i    (ex_mem_signals),
		.wb_signals_i     (ex_wb_signals),
		.valid_o          (mem_valid),
		.seq_o            (mem_seq),
		.alu_result_o     (mem_alu_result),
		.data_wr_to_mem_o (mem_store_data),
		.write_reg_o      (mem_dest),
		.mem_signals_o    (mem_mem_signals),
		.wb_signals_o     (mem_wb_signals)
	);

	result_stage i_result_stage (
		.clock            (clock),
		.reset            (reset),
		.run_i            (run_i),
		.valid_i          (mem_valid),
		.seq_i            (mem_seq),
		.alu_result_i     (mem_alu_result),
		.data_wr_to_mem_i (mem_store_data),
		.write_reg_i      (mem_dest),
		.mem_signals_i    (mem_mem_signals),
		.wb_signals_i     (mem_wb_signals),
		.wr_en_o          (wr_en),
		.wr_reg_o         (wr_reg),
		.wr_data_o        (wr_data),
		.wb_valid_o       (wb_valid_o),
		.wb_seq_o         (wb_seq_o),
		.wb_write_o       (wb_write_o),
		.wb_reg_o         (wb_reg_o),
		.wb_data_o        (wb_data_o)
	);

endmodule

`default_nettype wire

//--- logic/result_stage.sv
`default_nettype none
`include "core_macros.svh"

module result_stage
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  run_i,
	input  logic                  valid_i,
	input  logic [`NB_SEQ-1:0]    seq_i,
	input  logic [`NB_DATA-1:0]   alu_result_i,
	input  logic [`NB_DATA-1:0]   data_wr_to_mem_i,
	input  logic [`NB_REGWR-1:0]  write_reg_i,
	input  logic [1:0]            mem_signals_i,
	input  logic [1:0]            wb_signals_i,
	output logic                  wr_en_o,
	output logic [`NB_REGWR-1:0]  wr_reg_o,
	output logic [`NB_DATA-1:0]   wr_data_o,
	output logic                  wb_valid_o,
	output logic [`NB_SEQ-1:0]    wb_seq_o,
	output logic                  wb_write_o,
	output logic [`NB_REGWR-1:0]  wb_reg_o,
	output logic [`NB_DATA-1:0]   wb_data_o
);

	localparam int NB_ADDR = $clog2(`DMEM_WORDS);

	logic [`NB_DATA-1:0] dmem [`DMEM_WORDS];
	logic [NB_ADDR-1:0]  addr;
	logic [`NB_DATA-1:0] load_data;
	logic                retire;

	// word addressed, low bits of the alu result
	assign addr = alu_result_i[NB_ADDR-1:0];
	assign load_data = mem_signals_i[1] ? dmem[addr] : '0;
	assign retire = run_i && valid_i;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int k = 0; k < `DMEM_WORDS; k++)
				dmem[k] <= '0;
		end
		else if (retire && mem_signals_i[0])
			dmem[addr] <= data_wr_to_mem_i;
	end

	// register file write lands on the same edge as the retire outputs
	assign wr_en_o = retire && wb_signals_i[1];
	assign wr_reg_o = write_reg_i;
	assign wr_data_o = wb_signals_i[0] ? load_data : alu_result_i;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wb_valid_o <= 1'b0;
			wb_write_o <= 1'b0;
		end
		else
		begin
			// one-cycle pulse, never while frozen
			wb_valid_o <= retire;
			if (retire)
				wb_write_o <= wb_signals_i[1];
		end
	end

	always_ff @(posedge clock)
	begin
		if (retire)
		begin
			wb_seq_o <= seq_i;
			wb_reg_o <= write_reg_i;
			wb_data_o <= wr_data_o;
		end
	end

	store_excludes_reg_write: assert property (@(posedge clock) disable iff (reset)
		valid_i |-> !(mem_signals_i[0] && wb_signals_i[1]))
		else $error("store and register write requested together, seq %0d", seq_i);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the pipe_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert -j 0 -f list.f \
	--top-module pipe_core_tb --Mdir "$obj" -o vpipe_core_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$obj/vpipe_core_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" "$log"; then
	exit 1
fi
if ! grep -q "Done: no errors" "$log"; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0

//--- verif/pipe_core_vectors.svh
`ifndef PIPE_CORE_VECTORS_SVH
`define PIPE_CORE_VECTORS_SVH

// columns: freeze cycles, random, opcode, rs, rt, rd, funct, immediate,
// expected-value check, expected write, expected write-back data

localparam int NUM_ROWS = 38;

task automatic fill_table();
	// first add after reset, all registers still zero
	put_row(4'd0, 1'b0, OP_RTYPE, 5'd1, 5'd2, 5'd3, FN_ADD, 16'h0000, 1'b1, 1'b1, 32'h0);
	put_row(4'd0, 1'b0, OP_ADDI, 5'd0, 5'd1, 5'd0, 6'd0, 16'h0005, 1'b1, 1'b1, 32'h5);
	// negative immediate
	put_row(4'd0, 1'b0, OP_ADDI, 5'd0, 5'd2, 5'd0, 6'd0, 16'hfffd, 1'b1, 1'b1, 32'hfffffffd);
	put_row(4'd0, 1'b0, OP_RTYPE, 5'd1, 5'd2, 5'd3, FN_ADD, 16'h0000, 1'b1, 1'b1, 32'h2);
	put_row(4'd2, 1'b0, OP_RTYPE, 5'd1, 5'd2, 5'd4, FN_SUB, 16'h0000, 1'b1, 1'b1, 32'h8);
	put_row(4'd0, 1'b0, OP_RTYPE, 5'd1, 5'd2, 5'd5, FN_AND, 16'h0000, 1'b1, 1'b1, 32'h5);
	put_row(4'd0, 1'b0, OP_RTYPE, 5'd1, 5'd2, 5'd6, FN_OR, 16'h0000, 1'b1, 1'b1, 32'hfffffffd);
	// signed compare, -3 < 5 and 5 < -3
	put_row(4'd0, 1'b0, OP_RTYPE, 5'd2, 5'd1, 5'd7, FN_SLT, 16'h0000, 1'b1, 1'b1, 32'h1);
	put_row(4'd0, 1'b0, OP_RTYPE, 5'd1, 5'd2, 5'd8, FN_SLT, 16'h0000, 1'b1, 1'b1, 32'h0);
	// ori zero-extends a high-bit immediate
	put_row(4'd0, 1'b0, OP_ORI, 5'd0, 5'd9, 5'd0, 6'd0, 16'h8001, 1'b1, 1'b1, 32'h8001);
	put_row(4'd3, 1'b0, OP_ORI, 5'd9, 5'd9, 5'd0, 6'd0, 16'h0ff0, 1'b1, 1'b1, 32'h8ff1);
	// store to word 7, then load it back
	put_row(4'd0, 1'b0, OP_SW, 5'd1, 5'd9, 5'd0, 6'd0, 16'h0002, 1'b1, 1'b0, 32'h0);
	put_row(4'd2, 1'b0, OP_LW, 5'd0, 5'd10, 5'd0, 6'd0, 16'h0007, 1'b1, 1'b1, 32'h8ff1);
	// write to r0 is dropped
	put_row(4'd0, 1'b0, OP_RTYPE, 5'd1, 5'd1, 5'd0, FN_ADD, 16'h0000, 1'b1, 1'b0, 32'h0);
	put_row(4'd0, 1'b0, OP_RTYPE, 5'd0, 5'd1, 5'd11, FN_ADD, 16'h0000, 1'b1, 1'b1, 32'h5);
	// unknown opcode
	put_row(4'd1, 1'b0, 6'd63, 5'd1, 5'd2, 5'd19, 6'd0, 16'h0000, 1'b1, 1'b0, 32'h0);
	put_row(4'd4, 1'b0, OP_ADDI, 5'd10, 5'd12, 5'd0, 6'd0, 16'hffff, 1'b1, 1'b1, 32'h8ff0);
	put_row(4'd0, 1'b0, OP_RTYPE, 5'd12, 5'd3, 5'd13, FN_SUB, 16'h0000, 1'b1, 1'b1, 32'h8fee);
	// unsupported funct
	put_row(4'd0, 1'b0, OP_RTYPE, 5'd1, 5'd2, 5'd14, 6'd0, 16'h0000, 1'b1, 1'b0, 32'h0);
	// only the low address bits pick the word
	put_row(4'd0, 1'b0, OP_LW, 5'd12, 5'd15, 5'd0, 6'd0, 16'h0007, 1'b1, 1'b1, 32'h8ff1);
	put_row(4'd0, 1'b0, OP_SW, 5'd0, 5'd4, 5'd0, 6'd0, 16'hfff3, 1'b1, 1'b0, 32'h0);
	put_row(4'd1, 1'b0, OP_LW, 5'd0, 5'd16, 5'd0, 6'd0, 16'h0003, 1'b1, 1'b1, 32'h8);
	put_row(4'd0, 1'b0, OP_RTYPE, 5'd16, 5'd13, 5'd17, FN_SLT, 16'h0000, 1'b1, 1'b1, 32'h1);
	put_row(4'd0, 1'b0, OP_RTYPE, 5'd17, 5'd9, 5'd18, FN_OR, 16'h0000, 1'b1, 1'b1, 32'h8ff1);
	put_row(4'd0, 1'b0, OP_ADDI, 5'd1, 5'd0, 5'd0, 6'd0, 16'h0005, 1'b1, 1'b0, 32'h0);
	put_row(4'd0, 1'b0, OP_RTYPE, 5'd0, 5'd0, 5'd20, FN_OR, 16'h0000, 1'b1, 1'b1, 32'h0);
	// random registers and immediates, model only
	put_row(4'd0, 1'b1, OP_ADDI, 5'd0, 5'd0, 5'd0, 6'd0, 16'h0000, 1'b0, 1'b0, 32'h0);
	put_row(4'd0, 1'b1, OP_RTYPE, 5'd0, 5'd0, 5'd0, FN_ADD, 16'h0000, 1'b0, 1'b0, 32'h0);
	put_row(4'd2, 1'b1, OP_RTYPE, 5'd0, 5'd0, 5'd0, FN_SUB, 16'h0000, 1'b0, 1'b0, 32'h0);
	put_row(4'd0, 1'b1, OP_ORI, 5'd0, 5'd0, 5'd0, 6'd0, 16'h0000, 1'b0, 1'b0, 32'h0);
	put_row(4'd0, 1'b1, OP_SW, 5'd0, 5'd0, 5'd0, 6'd0, 16'h0000, 1'b0, 1'b0, 32'h0);
	put_row(4'd0, 1'b1, OP_LW, 5'd0, 5'd0, 5'd0, 6'd0, 16'h0000, 1'b0, 1'b0, 32'h0);
	put_row(4'd1, 1'b1, OP_RTYPE, 5'd0, 5'd0, 5'd0, FN_SLT, 16'h0000, 1'b0, 1'b0, 32'h0);
	put_row(4'd0, 1'b1, OP_RTYPE, 5'd0, 5'd0, 5'd0, FN_AND, 16'h0000, 1'b0, 1'b0, 32'h0);
	put_row(4'd0, 1'b1, OP_ADDI, 5'd0, 5'd0, 5'd0, 6'd0, 16'h0000, 1'b0, 1'b0, 32'h0);
	put_row(4'd3, 1'b1, OP_RTYPE, 5'd0, 5'd0, 5'd0, FN_OR, 16'h0000, 1'b0, 1'b0, 32'h0);
	put_row(4'd0, 1'b1, OP_SW, 5'd0, 5'd0, 5'd0, 6'd0, 16'h0000, 1'b0, 1'b0, 32'h0);
	put_row(4'd0, 1'b1, OP_LW, 5'd0, 5'd0, 5'd0, 6'd0, 16'h0000, 1'b0, 1'b0, 32'h0);
endtask

`endif

//--- verif/pipe_core_tb.sv
`default_nettype none
`include "core_macros.svh"

module pipe_core_tb import core_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	`include "pipe_core_vectors.svh"

	localparam int TIMEOUT_CYCLES = 20 * NUM_ROWS + 100;
	localparam int NB_DADDR = $clog2(`DMEM_WORDS);

	logic                  clock = 1'b0;
	logic                  reset;
	logic                  run_i;
	logic                  instr_req_i;
	logic [`NB_DATA-1:0]   instr_i;
	logic                  instr_ack_o;
	logic                  wb_valid_o;
	logic [`NB_SEQ-1:0]    wb_seq_o;
	logic                  wb_write_o;
	logic [`NB_REGWR-1:0]  wb_reg_o;
	logic [`NB_DATA-1:0]   wb_data_o;

	// stimulus table
	logic [3:0]   tab_frz [NUM_ROWS];
	logic         tab_rnd [NUM_ROWS];
	logic [5:0]   tab_op [NUM_ROWS];
	logic [4:0]   tab_rs [NUM_ROWS];
	logic [4:0]   tab_rt [NUM_ROWS];
	logic [4:0]   tab_rd [NUM_ROWS];
	logic [5:0]   tab_fn [NUM_ROWS];
	logic [15:0]  tab_imm [NUM_ROWS];
	logic         tab_chk [NUM_ROWS];
	logic         tab_wr [NUM_ROWS];
	logic [31:0]  tab_data [NUM_ROWS];
	int           n_rows = 0;

	// architectural state of the reference model
	logic [`NB_DATA-1:0]   model_regs [32];
	logic [`NB_DATA-1:0]   model_mem [`DMEM_WORDS];

	// predicted retires, in issue order
	logic [`NB_SEQ-1:0]    exp_seq_q [$];
	logic                  exp_wr_q [$];
	logic [`NB_REGWR-1:0]  exp_reg_q [$];
	logic [`NB_DATA-1:0]   exp_data_q [$];

	logic [`NB_SEQ-1:0]    exp_seq = '0;
	logic [31:0]           rng = 32'h1d5;
	logic                  run_at_edge = 1'b1;
	logic                  head_wr;
	int                    cycle_count = 0;
	int                    retired = 0;
	int                    mismatch_count = 0;
	int                    retire_errors = 0;
	int                    drive_errors = 0;

	pipe_core i_pipe_core (
		.clock       (clock),
		.reset       (reset),
		.run_i       (run_i),
		.instr_req_i (instr_req_i),
		.instr_i     (instr_i),
		.instr_ack_o (instr_ack_o),
		.wb_valid_o  (wb_valid_o),
		.wb_seq_o    (wb_seq_o),
		.wb_write_o  (wb_write_o),
		.wb_reg_o    (wb_reg_o),
		.wb_data_o   (wb_data_o)
	);

	always #4 clock = ~clock;

	task automatic put_row(input logic [3:0] frz, input logic rnd, input logic [5:0] op,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
		input logic [5:0] fn, input logic [15:0] imm,
		input logic chk, input logic wr, input logic [31:0] data);
		if (n_rows < NUM_ROWS)
		begin
			tab_frz[n_rows] = frz;
			tab_rnd[n_rows] = rnd;
			tab_op[n_rows] = op;
			tab_rs[n_rows] = rs;
			tab_rt[n_rows] = rt;
			tab_rd[n_rows] = rd;
			tab_fn[n_rows] = fn;
			tab_imm[n_rows] = imm;
			tab_chk[n_rows] = chk;
			tab_wr[n_rows] = wr;
			tab_data[n_rows] = data;
		end
		n_rows++;
	endtask

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// architectural result of one instruction, updates the model state
	task automatic predict(input logic [5:0] op, input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] fn, input logic [15:0] imm,
		output logic wr, output logic [4:0] dst, output logic [31:0] val);
		logic [31:0]         a;
		logic [31:0]         b;
		logic [31:0]         sum;
		logic [NB_DADDR-1:0] addr;
		a = model_regs[rs];
		b = model_regs[rt];
		sum = a + {{16{imm[15]}}, imm};
		addr = sum[NB_DADDR-1:0];
		wr = 1'b0;
		dst = rt;
		val = '0;
		case (op)
			OP_RTYPE:
			begin
				dst = rd;
				wr = 1'b1;
				case (fn)
					FN_ADD: val = a + b;
					FN_SUB: val = a - b;
					FN_AND: val = a & b;
					FN_OR:  val = a | b;
					FN_SLT: val = {31'd0, $signed(a) < $signed(b)};
					default: wr = 1'b0;
				endcase
			end
			OP_ADDI:
			begin
				wr = 1'b1;
				val = sum;
			end
			OP_ORI:
			begin
				wr = 1'b1;
				val = a | {16'd0, imm};
			end
			OP_LW:
			begin
				wr = 1'b1;
				val = model_mem[addr];
			end
			OP_SW: model_mem[addr] = b;
			default: wr = 1'b0;
		endcase
		if (dst == 5'd0)
			wr = 1'b0;
		if (wr)
			model_regs[dst] = val;
	endtask

	// four-phase transfer of one row, starts and ends on a falling edge
	task automatic apply_row(input int r);
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		logic        wr;
		logic [4:0]  dst;
		logic [31:0] val;
		rs = tab_rs[r];
		rt = tab_rt[r];
		rd = tab_rd[r];
		imm = tab_imm[r];
		if (tab_rnd[r])
		begin
			rng = next_random(rng);
			rs = rng[4:0];
			rt = rng[9:5];
			rd = rng[14:10];
			imm = rng[31:16];
		end
		predict(tab_op[r], rs, rt, rd, tab_fn[r], imm, wr, dst, val);
		if (tab_chk[r])
		begin
			assert (wr == tab_wr[r] && (!wr || val == tab_data[r]))
			else
			begin
				$display("row %0d: reference model and table expect different results", r);
				drive_errors++;
			end
			wr = tab_wr[r];
			val = tab_data[r];
		end
		exp_seq_q.push_back(exp_seq);
		exp_wr_q.push_back(wr);
		exp_reg_q.push_back(dst);
		exp_data_q.push_back(val);
		exp_seq = exp_seq + 1'b1;

		if (tab_op[r] inside {OP_ADDI, OP_ORI, OP_LW, OP_SW})
			instr_i = {tab_op[r], rs, rt, imm};
		else
			instr_i = {tab_op[r], rs, rt, rd, 5'd0, tab_fn[r]};
		instr_req_i = 1'b1;
		// freeze with earlier instructions still in flight
		if (tab_frz[r] != 4'd0)
		begin
			run_i = 1'b0;
			repeat (tab_frz[r]) @(negedge clock);
			run_i = 1'b1;
		end
		@(negedge clock);
		while (!instr_ack_o)
			@(negedge clock);
		instr_req_i = 1'b0;
		@(negedge clock);
		while (instr_ack_o)
			@(negedge clock);
	endtask

	task automatic check_field(input string name, input logic [31:0] got,
		input logic [31:0] want);
		assert (got === want)
		else
		begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, want);
			mismatch_count++;
		end
	endtask

	always @(posedge clock)
		run_at_edge <= run_i;

	// retire monitor, outputs settle after the rising edge
	always @(negedge clock)
	begin
		if (!reset && wb_valid_o)
		begin
			retired++;
			assert (run_at_edge)
			else
			begin
				$display("wb_valid_o pulsed at %0t after an edge with run_i low", $time);
				retire_errors++;
			end
			if (exp_seq_q.size() == 0)
			begin
				$display("instruction retired at %0t with none outstanding", $time);
				retire_errors++;
			end
			else
			begin
				head_wr = exp_wr_q.pop_front();
				check_field("wb_seq_o", 32'(wb_seq_o), 32'(exp_seq_q.pop_front()));
				check_field("wb_write_o", 32'(wb_write_o), 32'(head_wr));
				// register and data only matter when something is written
				if (head_wr)
				begin
					check_field("wb_reg_o", 32'(wb_reg_o), 32'(exp_reg_q.pop_front()));
					check_field("wb_data_o", wb_data_o, exp_data_q.pop_front());
				end
				else
				begin
					void'(exp_reg_q.pop_front());
					void'(exp_data_q.pop_front());
				end
			end
		end
	end

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, the pipeline did not finish", cycle_count);
			$display("Done: errors found");
			$finish;
		end
	end

	initial
	begin
		reset = 1'b1;
		run_i = 1'b1;
		instr_req_i = 1'b0;
		instr_i = '0;
		for (int k = 0; k < 32; k++)
			model_regs[k] = '0;
		for (int k = 0; k < `DMEM_WORDS; k++)
			model_mem[k] = '0;
		fill_table();
		assert (n_rows == NUM_ROWS)
		else
		begin
			$display("table holds %0d rows instead of %0d", n_rows, NUM_ROWS);
			drive_errors++;
		end

		// quiet outputs through reset and the first idle cycles
		for (int c = 0; c < 13; c++)
		begin
			@(negedge clock);
			if (c == 9)
				reset = 1'b0;
			assert (!wb_valid_o && !instr_ack_o)
			else
			begin
				$display("wb_valid_o or instr_ack_o high at %0t after reset", $time);
				drive_errors++;
			end
		end

		for (int r = 0; r < NUM_ROWS; r++)
			apply_row(r);

		while (exp_seq_q.size() != 0)
			@(negedge clock);
		repeat (8) @(negedge clock);
		assert (retired == NUM_ROWS)
		else
		begin
			$display("%0d instructions retired, %0d were issued", retired, NUM_ROWS);
			drive_errors++;
		end

		$display("errors: %0d mismatches, %0d retire errors, %0d stimulus errors",
			mismatch_count, retire_errors, drive_errors);
		if (mismatch_count == 0 && retire_errors == 0 && drive_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire
